//--- include/conductor_params.svh
`ifndef CONDUCTOR_PARAMS_SVH
`define CONDUCTOR_PARAMS_SVH

// camera position counts
`define CAM_H_W 11          // up to 2047 pixels per line
`define CAM_V_W 10          // up to 1023 lines per frame

// red chroma, Cr = offset + (KR*R - KG*G - KB*B) / 256
`define CR_KR 112
`define CR_KG 94
`define CR_KB 18
`define CR_OFFSET 128

// tempo from frame interval, 60 frames/s times 60 s
`define FRAMES_PER_MINUTE 3600

// centroid accumulators, also the centroid divider width
`define SUM_W 32

// frames between beats, 3600 must fit
`define FRAME_CNT_W 12

`endif

//--- src/conductor_pkg.sv
`include "conductor_params.svh"

package conductor_pkg;

  typedef logic [`CAM_H_W-1:0] hcount_t;  // column of a pixel
  typedef logic [`CAM_V_W-1:0] vcount_t;  // line of a pixel
  typedef logic [15:0]         rgb565_t;  // r[15:11] g[10:5] b[4:0]
  typedef logic [7:0]          chroma_t;  // chroma value or threshold bound
  typedef logic [7:0]          bpm_t;     // beats per minute

  // rebuilt camera pixel with its position
  typedef struct packed {
    rgb565_t data;
    hcount_t hcount;
    vcount_t vcount;
  } cam_pixel_t;

  // thresholded pixel, position rides along with the mask bit
  typedef struct packed {
    logic    mask;
    hcount_t hcount;
    vcount_t vcount;
  } mask_pixel_t;

  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } com_t;

  // codes follow the old switch settings
  typedef enum logic [1:0] {
    TEMPO_HOLD   = 2'b00,
    TEMPO_BATON  = 2'b01,
    TEMPO_MANUAL = 2'b10
  } tempo_mode_e;

endpackage

//--- src/pixel_reconstruct.sv
`timescale 1ns/1ns

module pixel_reconstruct (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  logic [7:0]                cam_data_i,
  input  logic                      cam_pclk_i,
  input  logic                      cam_hsync_i,
  input  logic                      cam_vsync_i,
  output logic                      pixel_valid_o,
  output conductor_pkg::cam_pixel_t pixel_o,
  output logic                      frame_end_o
);

  // [0],[1] synchronizer, [2] aligned sample, [3] previous sample for edges
  logic [3:0] pclk_sr;
  logic [3:0] hs_sr;
  logic [3:0] vs_sr;
  logic [7:0] data_s1;
  logic [7:0] data_s2;
  logic [7:0] data_q;             // lines up with pclk_sr[2]
  logic       pclk_rise;
  logic       hs_fall;
  logic       vs_rise;
  logic       second_byte;        // next captured byte is the low byte
  logic [7:0] high_byte;
  conductor_pkg::hcount_t hcount;
  conductor_pkg::vcount_t vcount;

  assign pclk_rise = pclk_sr[2] && !pclk_sr[3];
  assign hs_fall   = !hs_sr[2] && hs_sr[3];   // end of a line
  assign vs_rise   = vs_sr[2] && !vs_sr[3];   // end of a frame

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
    data_q  <= data_s2;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sr       <= '0;
      hs_sr         <= '0;
      vs_sr         <= '0;
      pixel_valid_o <= 1'b0;
      frame_end_o   <= 1'b0;
      second_byte   <= 1'b0;
      hcount        <= '0;
      vcount        <= '0;
    end else begin
      pclk_sr       <= {pclk_sr[2:0], cam_pclk_i};
      hs_sr         <= {hs_sr[2:0], cam_hsync_i};
      vs_sr         <= {vs_sr[2:0], cam_vsync_i};
      pixel_valid_o <= 1'b0;
      frame_end_o   <= vs_rise;
      if (vs_sr[2]) begin
        vcount <= '0;                          // held at top while vsync is up
      end else if (hs_fall) begin
        vcount <= vcount + 1'b1;
      end
      if (!hs_sr[2]) begin
        second_byte <= 1'b0;                   // pairing restarts in blanking
        hcount      <= '0;
      end else if (pclk_rise) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          pixel_valid_o <= 1'b1;               // pair complete
          hcount        <= hcount + 1'b1;
        end
      end
    end
  end

  // byte pairing payload, high byte first
  always_ff @(posedge clk_camera) begin
    if (pclk_rise && hs_sr[2]) begin
      if (!second_byte) begin
        high_byte <= data_q;
      end else begin
        pixel_o.data   <= {high_byte, data_q};
        pixel_o.hcount <= hcount;
        pixel_o.vcount <= vcount;
      end
    end
  end

endmodule

//--- src/chroma_threshold.sv
`timescale 1ns/1ns
`include "conductor_params.svh"

module chroma_threshold (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  logic                       pixel_valid_i,
  input  conductor_pkg::cam_pixel_t  pixel_i,
  input  conductor_pkg::chroma_t     threshold_lo_i,
  input  conductor_pkg::chroma_t     threshold_hi_i,
  output logic                       mask_valid_o,
  output conductor_pkg::mask_pixel_t mask_o
);

  localparam logic signed [17:0] KR = `CR_KR;
  localparam logic signed [17:0] KG = `CR_KG;
  localparam logic signed [17:0] KB = `CR_KB;
  localparam logic signed [17:0] OFFSET = `CR_OFFSET;

  logic signed [17:0] r_s;     // channels expanded to 8 bits
  logic signed [17:0] g_s;
  logic signed [17:0] b_s;
  logic signed [17:0] cr_raw;
  conductor_pkg::chroma_t cr_clamped;
  logic                   s1_valid;
  conductor_pkg::chroma_t s1_cr;
  conductor_pkg::hcount_t s1_hcount;
  conductor_pkg::vcount_t s1_vcount;

  always_comb begin
    r_s    = $signed({10'b0, pixel_i.data[15:11], 3'b0});
    g_s    = $signed({10'b0, pixel_i.data[10:5], 2'b0});
    b_s    = $signed({10'b0, pixel_i.data[4:0], 3'b0});
    cr_raw = OFFSET + ((KR * r_s - KG * g_s - KB * b_s) >>> 8);
    // clamp into 0..255
    if (cr_raw < 0) cr_clamped = 8'd0;
    else if (cr_raw > 18'sd255) cr_clamped = 8'd255;
    else cr_clamped = cr_raw[7:0];
  end

  // valid strobes of both stages
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      s1_valid     <= 1'b0;
      mask_valid_o <= 1'b0;
    end else begin
      s1_valid     <= pixel_valid_i;
      mask_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk_camera) begin
    s1_cr         <= cr_clamped;       // stage 1 chroma
    s1_hcount     <= pixel_i.hcount;
    s1_vcount     <= pixel_i.vcount;
    mask_o.mask   <= (s1_cr >= threshold_lo_i) && (s1_cr <= threshold_hi_i);  // inclusive
    mask_o.hcount <= s1_hcount;
    mask_o.vcount <= s1_vcount;
  end

endmodule

//--- src/serial_divider.sv
`timescale 1ns/1ns

module serial_divider #(
  parameter int WIDTH = 32
) (
  input  logic             clk_camera,
  input  logic             recent_reset,
  input  logic             start_i,
  input  logic [WIDTH-1:0] dividend_i,
  input  logic [WIDTH-1:0] divisor_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [WIDTH-1:0] quotient_o
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  logic [CNT_W-1:0] bits_left;   // quotient bits still to produce
  logic [WIDTH-1:0] rem_q;
  logic [WIDTH-1:0] quo_q;       // dividend shifts out, quotient shifts in
  logic [WIDTH-1:0] div_q;
  logic [WIDTH:0]   rem_shift;
  logic [WIDTH:0]   rem_trial;

  assign rem_shift  = {rem_q, quo_q[WIDTH-1]};
  assign rem_trial  = rem_shift - {1'b0, div_q};   // msb set when divisor does not fit
  assign quotient_o = quo_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      busy_o    <= 1'b0;
      done_o    <= 1'b0;
      bits_left <= '0;
    end else begin
      done_o <= 1'b0;
      if (!busy_o) begin
        if (start_i) begin
          busy_o    <= 1'b1;
          bits_left <= CNT_W'(WIDTH);
        end
      end else if (bits_left != '0) begin
        bits_left <= bits_left - 1'b1;
      end else begin
        busy_o <= 1'b0;   // last bit done the cycle before
        done_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (!busy_o && start_i) begin
      rem_q <= '0;
      quo_q <= dividend_i;
      div_q <= divisor_i;
    end else if (busy_o && bits_left != '0) begin
      if (!rem_trial[WIDTH]) begin
        rem_q <= rem_trial[WIDTH-1:0];              // subtract and keep
        quo_q <= {quo_q[WIDTH-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[WIDTH-1:0];              // restore
        quo_q <= {quo_q[WIDTH-2:0], 1'b0};
      end
    end
  end

endmodule

//--- src/center_of_mass.sv
`timescale 1ns/1ns
`include "conductor_params.svh"

module center_of_mass (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  logic                       mask_valid_i,
  input  conductor_pkg::mask_pixel_t mask_i,
  input  logic                       frame_end_i,
  output logic                       com_valid_o,
  output conductor_pkg::com_t        com_o
);

  logic              hit;        // masked pixel this cycle
  logic [`SUM_W-1:0] add_x;
  logic [`SUM_W-1:0] add_y;
  logic [`SUM_W-1:0] add_n;
  logic [`SUM_W-1:0] sum_x;
  logic [`SUM_W-1:0] sum_y;
  logic [`SUM_W-1:0] sum_n;
  logic              start;
  logic              done_x;
  logic              done_y;
  logic [`SUM_W-1:0] quo_x;
  logic [`SUM_W-1:0] quo_y;

  assign hit = mask_valid_i && mask_i.mask;

  always_comb begin
    add_x = hit ? `SUM_W'(mask_i.hcount) : '0;
    add_y = hit ? `SUM_W'(mask_i.vcount) : '0;
    add_n = hit ? `SUM_W'(1) : '0;
  end

  // empty frame starts nothing, so no com_valid_o for it
  assign start = frame_end_i && (sum_n != '0);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      sum_x <= '0;
      sum_y <= '0;
      sum_n <= '0;
    end else if (frame_end_i) begin
      // dividers took this frame's sums, next frame begins here
      sum_x <= add_x;
      sum_y <= add_y;
      sum_n <= add_n;
    end else begin
      sum_x <= sum_x + add_x;
      sum_y <= sum_y + add_y;
      sum_n <= sum_n + add_n;
    end
  end

  serial_divider #(.WIDTH(`SUM_W)) div_x (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .start_i     (start),
    .dividend_i  (sum_x),
    .divisor_i   (sum_n),
    .busy_o      (),
    .done_o      (done_x),
    .quotient_o  (quo_x)
  );

  serial_divider #(.WIDTH(`SUM_W)) div_y (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .start_i     (start),
    .dividend_i  (sum_y),
    .divisor_i   (sum_n),
    .busy_o      (),
    .done_o      (done_y),
    .quotient_o  (quo_y)
  );

  // centroid holds until the next non-empty frame
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      com_valid_o <= 1'b0;
      com_o       <= '0;
    end else begin
      com_valid_o <= done_x && done_y;
      if (done_x && done_y) begin
        com_o.x <= quo_x[`CAM_H_W-1:0];   // mean fits the count width
        com_o.y <= quo_y[`CAM_V_W-1:0];
      end
    end
  end

endmodule

//--- src/baton_tracker.sv
`timescale 1ns/1ns

module baton_tracker (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                com_valid_i,
  input  conductor_pkg::com_t com_i,
  output logic                beat_o
);

  conductor_pkg::vcount_t prev_y;
  logic                   have_prev;    // first centroid only seeds prev_y
  logic                   moving_down;  // y growing, baton heading to the bottom

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      prev_y      <= '0;
      have_prev   <= 1'b0;
      moving_down <= 1'b0;
      beat_o      <= 1'b0;
    end else begin
      beat_o <= 1'b0;
      if (com_valid_i) begin
        prev_y    <= com_i.y;
        have_prev <= 1'b1;
        if (have_prev) begin
          if (com_i.y > prev_y) begin
            moving_down <= 1'b1;
          end else if (com_i.y < prev_y) begin
            moving_down <= 1'b0;
            beat_o      <= moving_down;   // bottom of the stroke
          end
          // equal y keeps the direction
        end
      end
    end
  end

endmodule

//--- src/tempo_counter.sv
`timescale 1ns/1ns
`include "conductor_params.svh"

module tempo_counter (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  conductor_pkg::tempo_mode_e mode_i,
  input  conductor_pkg::bpm_t        manual_bpm_i,
  input  logic                       beat_i,
  input  logic                       frame_end_i,
  output conductor_pkg::bpm_t        bpm_o
);

  logic [`FRAME_CNT_W-1:0] frames;    // frame ends since the last beat
  logic                    start;
  logic                    done;
  logic [`FRAME_CNT_W-1:0] quotient;

  assign start = beat_i && (mode_i == conductor_pkg::TEMPO_BATON) && (frames != '0);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      frames <= '0;
    end else if (beat_i) begin
      frames <= `FRAME_CNT_W'(frame_end_i);  // interval restarts at every beat
    end else if (frame_end_i && frames != '1) begin
      frames <= frames + 1'b1;               // saturates
    end
  end

  serial_divider #(.WIDTH(`FRAME_CNT_W)) div_bpm (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .start_i     (start),
    .dividend_i  (`FRAME_CNT_W'(`FRAMES_PER_MINUTE)),
    .divisor_i   (frames),
    .busy_o      (),
    .done_o      (done),
    .quotient_o  (quotient)
  );

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      bpm_o <= '0;
    end else begin
      case (mode_i)
        conductor_pkg::TEMPO_MANUAL: bpm_o <= manual_bpm_i;
        conductor_pkg::TEMPO_BATON: begin
          if (done) begin
            // short intervals would overflow 8 bits
            bpm_o <= (quotient > `FRAME_CNT_W'(255)) ? 8'd255 : quotient[7:0];
          end
        end
        default: bpm_o <= bpm_o;               // hold
      endcase
    end
  end

endmodule

//--- src/conductor_top.sv
`timescale 1ns/1ns

module conductor_top (
  input  logic                       clk_camera,
  input  logic                       recent_reset,
  input  logic [7:0]                 cam_data_i,
  input  logic                       cam_pclk_i,
  input  logic                       cam_hsync_i,
  input  logic                       cam_vsync_i,
  input  conductor_pkg::chroma_t     threshold_lo_i,
  input  conductor_pkg::chroma_t     threshold_hi_i,
  input  conductor_pkg::tempo_mode_e mode_i,
  input  conductor_pkg::bpm_t        manual_bpm_i,
  output logic                       com_valid_o,
  output conductor_pkg::com_t        com_o,
  output logic                       beat_o,
  output conductor_pkg::bpm_t        bpm_o
);

  logic                       pixel_valid;
  conductor_pkg::cam_pixel_t  pixel;
  logic                       frame_end;   // vsync rise, shared by centroid and tempo
  logic                       mask_valid;
  conductor_pkg::mask_pixel_t mask;

  pixel_reconstruct u_pixel (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .cam_data_i(cam_data_i), .cam_pclk_i(cam_pclk_i),
    .cam_hsync_i(cam_hsync_i), .cam_vsync_i(cam_vsync_i),
    .pixel_valid_o(pixel_valid), .pixel_o(pixel), .frame_end_o(frame_end)
  );

  chroma_threshold u_chroma (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .pixel_valid_i(pixel_valid), .pixel_i(pixel),
    .threshold_lo_i(threshold_lo_i), .threshold_hi_i(threshold_hi_i),
    .mask_valid_o(mask_valid), .mask_o(mask)
  );

  center_of_mass u_com (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .mask_valid_i(mask_valid), .mask_i(mask), .frame_end_i(frame_end),
    .com_valid_o(com_valid_o), .com_o(com_o)
  );

  baton_tracker u_baton (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .com_valid_i(com_valid_o), .com_i(com_o), .beat_o(beat_o)
  );

  tempo_counter u_tempo (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .mode_i(mode_i), .manual_bpm_i(manual_bpm_i),
    .beat_i(beat_o), .frame_end_i(frame_end), .bpm_o(bpm_o)
  );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o
);

  // low at time 0, first rising edge at 5 ns
  initial clk_o = 1'b0;

  always #5 clk_o = ~clk_o;  // 10 ns period

endmodule

//--- sim/conductor_tb.sv
`timescale 1ns/1ns
`include "conductor_params.svh"

module conductor_tb;

  logic                       clk_camera;
  logic                       recent_reset;
  logic [7:0]                 cam_data;
  logic                       cam_pclk;
  logic                       cam_hsync;
  logic                       cam_vsync;
  conductor_pkg::chroma_t     threshold_lo;
  conductor_pkg::chroma_t     threshold_hi;
  conductor_pkg::tempo_mode_e mode;
  conductor_pkg::bpm_t        manual_bpm;
  logic                       com_valid;
  conductor_pkg::com_t        com;
  logic                       beat;
  conductor_pkg::bpm_t        bpm;

  logic [15:0]         lfsr;          // galois lfsr state
  int                  beats_seen;    // beat pulses counted by the monitor
  int                  exp_beats;
  int                  frames_since;  // frame ends since the last expected beat
  logic                have_prev;     // model of the baton direction
  logic                moving_down;
  int                  prev_y;
  conductor_pkg::com_t exp_com;
  conductor_pkg::bpm_t exp_bpm;
  int                  bx;            // blob corner and size
  int                  by;
  int                  bw;
  int                  bh;

  tb_clock u_clock (.clk_o(clk_camera));

  conductor_top uut (
    .clk_camera(clk_camera), .recent_reset(recent_reset),
    .cam_data_i(cam_data), .cam_pclk_i(cam_pclk),
    .cam_hsync_i(cam_hsync), .cam_vsync_i(cam_vsync),
    .threshold_lo_i(threshold_lo), .threshold_hi_i(threshold_hi),
    .mode_i(mode), .manual_bpm_i(manual_bpm),
    .com_valid_o(com_valid), .com_o(com), .beat_o(beat), .bpm_o(bpm)
  );

  // counts every beat pulse including unexpected ones
  always @(posedge clk_camera) begin
    if (!recent_reset && beat) beats_seen <= beats_seen + 1;
  end

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped on timeout");
  endtask

  // bits come out msb first with one lfsr step each
  function automatic int draw_bits(input int n);
    int i;
    int val;
    val = 0;
    for (i = 0; i < n; i++) begin
      val  = (val << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return val;
  endfunction

  // pclk low for 2 cycles with the byte and high for 2 more
  task automatic send_byte(input logic [7:0] b);
    @(negedge clk_camera);
    cam_pclk = 1'b0;
    cam_data = b;
    @(negedge clk_camera);
    @(negedge clk_camera);
    cam_pclk = 1'b1;  // rising edge takes the byte
    @(negedge clk_camera);
  endtask

  // 16x8 grey frame with a red blob and a closing vsync pulse
  task automatic send_frame(input int x0, input int y0, input int w, input int h);
    int   row;
    int   col;
    logic red;
    for (row = 0; row < 8; row++) begin
      @(negedge clk_camera);
      cam_hsync = 1'b1;
      for (col = 0; col < 16; col++) begin
        red = (col >= x0) && (col < x0 + w) && (row >= y0) && (row < y0 + h);
        send_byte(red ? 8'hF8 : 8'h84);  // high byte of F800 or 8410 first
        send_byte(red ? 8'h00 : 8'h10);
      end
      @(negedge clk_camera);
      cam_hsync = 1'b0;
      cam_pclk  = 1'b0;
      repeat (8) @(negedge clk_camera);  // line blanking
    end
    cam_vsync = 1'b1;
    repeat (8) @(negedge clk_camera);
    cam_vsync = 1'b0;
    repeat (8) @(negedge clk_camera);
  endtask

  task automatic wait_bpm(input conductor_pkg::bpm_t v);
    int waited;
    for (waited = 0; waited < 40 && bpm != v; waited++) @(negedge clk_camera);
    assert (bpm == v) else fail_check($sformatf("bpm_o is %0d, expected %0d", bpm, v));
  endtask

  // sends one frame and checks centroid, beat and tempo against the model
  task automatic run_frame(input int x0, input int y0, input int w, input int h);
    int   row;
    int   col;
    int   sx;
    int   sy;
    int   n;
    int   waited;
    logic exp_beat;
    sx = 0;
    sy = 0;
    n  = 0;
    for (row = 0; row < 8; row++) begin
      for (col = 0; col < 16; col++) begin
        if ((col >= x0) && (col < x0 + w) && (row >= y0) && (row < y0 + h)) begin
          sx += col;
          sy += row;
          n++;
        end
      end
    end
    assert (beats_seen == exp_beats) else fail_check("beat_o pulse count differs from model");
    send_frame(x0, y0, w, h);
    frames_since++;
    if (n == 0) begin
      for (waited = 0; waited < 60; waited++) begin
        @(negedge clk_camera);
        assert (!com_valid) else fail_check("com_valid_o pulsed for a frame with no red");
      end
      assert (com == exp_com) else fail_check("com_o changed after a frame with no red");
    end else begin
      exp_com.x = conductor_pkg::hcount_t'(sx / n);  // floor of the mean
      exp_com.y = conductor_pkg::vcount_t'(sy / n);
      for (waited = 0; waited < 200 && !com_valid; waited++) @(negedge clk_camera);
      if (!com_valid) report_timeout("com_valid_o after a frame end");
      assert (com == exp_com) else fail_check($sformatf(
        "centroid x=%0d y=%0d, expected x=%0d y=%0d", com.x, com.y, exp_com.x, exp_com.y));
      exp_beat = 1'b0;
      if (have_prev) begin
        if (exp_com.y > prev_y) moving_down = 1'b1;
        else if (exp_com.y < prev_y) begin
          exp_beat    = moving_down;  // bottom of a stroke
          moving_down = 1'b0;
        end
      end
      prev_y    = exp_com.y;
      have_prev = 1'b1;
      @(negedge clk_camera);
      assert (beat == exp_beat) else fail_check($sformatf("beat_o is %0b, expected %0b",
        beat, exp_beat));
      if (exp_beat) begin
        exp_beats++;
        if (mode == conductor_pkg::TEMPO_BATON) begin
          exp_bpm = (`FRAMES_PER_MINUTE / frames_since > 255) ? 8'd255
                  : 8'(`FRAMES_PER_MINUTE / frames_since);
          wait_bpm(exp_bpm);
        end else begin
          for (waited = 0; waited < 30; waited++) begin
            @(negedge clk_camera);
            assert (bpm == exp_bpm) else fail_check("bpm_o moved while tempo is held");
          end
        end
        frames_since = 0;
      end
    end
  endtask

  // blob goes down then jumps to the top so each stroke of len frames gives one beat
  task automatic run_stroke(input int len);
    int k;
    for (k = 0; k < len; k++) begin
      run_frame(4, (k == len - 1) ? 0 : ((k + 1 > 7) ? 7 : k + 1), 6, 1);
    end
  endtask

  initial begin
    lfsr         = 16'd26;
    beats_seen   = 0;
    exp_beats    = 0;
    frames_since = 0;
    have_prev    = 1'b0;
    moving_down  = 1'b0;
    prev_y       = 0;
    exp_com      = '0;
    exp_bpm      = '0;
    recent_reset = 1'b1;
    cam_data     = 8'h00;
    cam_pclk     = 1'b0;
    cam_hsync    = 1'b0;
    cam_vsync    = 1'b0;
    threshold_lo = 8'hA0;
    threshold_hi = 8'hF0;
    mode         = conductor_pkg::TEMPO_HOLD;
    manual_bpm   = 8'h00;
    repeat (5) @(negedge clk_camera);
    recent_reset = 1'b0;
    @(negedge clk_camera);
    assert (!com_valid && !beat && bpm == 0 && com == 0)
      else fail_check("outputs not idle after reset");
    repeat (8) begin
      bx = draw_bits(4);
      bw = draw_bits(3);
      by = draw_bits(3);
      bh = draw_bits(2);
      run_frame(bx, by, bw + 1, bh + 1);
    end
    run_frame(0, 0, 0, 0);  // all grey
    bx = draw_bits(4);
    bw = draw_bits(3);
    by = draw_bits(3);
    bh = draw_bits(2);
    run_frame(bx, by, bw + 1, bh + 1);
    mode = conductor_pkg::TEMPO_BATON;
    run_stroke(20);
    run_stroke(20);
    run_stroke(16);
    run_stroke(30);
    run_stroke(3);           // short interval saturates
    mode       = conductor_pkg::TEMPO_MANUAL;
    manual_bpm = 8'h5A;
    wait_bpm(8'h5A);
    manual_bpm = 8'hC3;
    wait_bpm(8'hC3);
    exp_bpm = 8'hC3;
    mode    = conductor_pkg::TEMPO_HOLD;
    run_stroke(5);
    run_stroke(5);
    repeat (4) @(negedge clk_camera);
    if (beats_seen != exp_beats) begin
      fail_check("beat_o pulse count differs from model at the end");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

//--- conductor_top.f
+incdir+include
src/conductor_pkg.sv
src/pixel_reconstruct.sv
src/chroma_threshold.sv
src/serial_divider.sv
src/center_of_mass.sv
src/baton_tracker.sv
src/tempo_counter.sv
src/conductor_top.sv
sim/tb_clock.sv
sim/conductor_tb.sv
